//--- Bender.yml
package:
  name: accel_ctrl

sources:
  - include_dirs:
      - src
    files:
      - src/accel_pkg.sv
      - src/mem_port_if.sv
      - src/task_sequencer.sv
      - src/feature_reader.sv
      - src/lane_operator.sv
      - src/return_writer.sv
      - src/mem_arbiter.sv
      - src/accel_ctrl_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - verification/accel_assert.sv
      - verification/accel_tb.sv

//--- filelist.f
+incdir+src
src/accel_pkg.sv
src/mem_port_if.sv
src/task_sequencer.sv
src/feature_reader.sv
src/lane_operator.sv
src/return_writer.sv
src/mem_arbiter.sv
src/accel_ctrl_top.sv
verification/accel_assert.sv
verification/accel_tb.sv

//--- src/accel_consts.svh
`ifndef ACCEL_CONSTS_SVH
`define ACCEL_CONSTS_SVH

// memory word and lane geometry
`define ACC_WORD_W 32
`define ACC_LANE_W 8
`define ACC_LANES (`ACC_WORD_W / `ACC_LANE_W)

// 256 word feature memory
`define ACC_ADDR_W 8

// patch count and patch length fields
`define ACC_CNT_W 8

// result fifo depth, also the reader credit at reset
`define ACC_FIFO_DEPTH 4

`endif

//--- src/accel_ctrl_top.sv
`include "accel_consts.svh"

module accel_ctrl_top import accel_pkg::*; (
	input  logic  system_clk,
	input  logic  rst_n,
	input  logic  task_start,
	input  logic  order_valid,
	input  op_e   order_op,
	input  addr_t order_src,
	input  addr_t order_dst,
	input  cnt_t  order_patch_num,
	input  cnt_t  order_patch_len,
	output logic  order_ready,
	output logic  op_done,
	output logic  task_active,
	output logic  mem_en,
	output logic  mem_we,
	output addr_t mem_addr,
	output word_t mem_wdata,
	input  word_t mem_rdata
);

	logic  patch_begin;
	logic  patch_done;
	logic  slot_free;
	logic  res_valid;
	word_t res_data;
	op_e   cur_op;
	addr_t patch_src;
	addr_t patch_dst;
	cnt_t  patch_len;

	mem_port_if rd_port ();
	mem_port_if wr_port ();

	task_sequencer u_task_sequencer (
		.system_clk      (system_clk),
		.rst_n           (rst_n),
		.task_start      (task_start),
		.order_valid     (order_valid),
		.order_op        (order_op),
		.order_src       (order_src),
		.order_dst       (order_dst),
		.order_patch_num (order_patch_num),
		.order_patch_len (order_patch_len),
		.patch_done      (patch_done),
		.order_ready     (order_ready),
		.op_done         (op_done),
		.task_active     (task_active),
		.patch_begin     (patch_begin),
		.cur_op          (cur_op),
		.patch_src       (patch_src),
		.patch_dst       (patch_dst),
		.patch_len       (patch_len)
	);

	feature_reader u_feature_reader (
		.system_clk  (system_clk),
		.rst_n       (rst_n),
		.patch_begin (patch_begin),
		.patch_src   (patch_src),
		.patch_len   (patch_len),
		.slot_free   (slot_free),
		.rd          (rd_port)
	);

	// read data goes straight into the operator
	lane_operator u_lane_operator (
		.system_clk (system_clk),
		.rst_n      (rst_n),
		.cur_op     (cur_op),
		.in_valid   (rd_port.rvalid),
		.in_data    (rd_port.rdata),
		.res_valid  (res_valid),
		.res_data   (res_data)
	);

	return_writer u_return_writer (
		.system_clk  (system_clk),
		.rst_n       (rst_n),
		.patch_begin (patch_begin),
		.patch_dst   (patch_dst),
		.patch_len   (patch_len),
		.res_valid   (res_valid),
		.res_data    (res_data),
		.slot_free   (slot_free),
		.patch_done  (patch_done),
		.wr          (wr_port)
	);

	mem_arbiter u_mem_arbiter (
		.system_clk (system_clk),
		.rst_n      (rst_n),
		.mem_rdata  (mem_rdata),
		.rd         (rd_port),
		.wr         (wr_port),
		.mem_en     (mem_en),
		.mem_we     (mem_we),
		.mem_addr   (mem_addr),
		.mem_wdata  (mem_wdata)
	);

endmodule

//--- src/accel_pkg.sv
`include "accel_consts.svh"

package accel_pkg;

	// order opcodes
	typedef enum logic [1:0] {
		op_add    = 2'd0,
		op_pool   = 2'd1,
		op_finish = 2'd2
	} op_e;

	typedef enum logic [2:0] {
		st_idle       = 3'd0,
		st_wait_order = 3'd1,
		st_load_patch = 3'd2,
		st_wait_patch = 3'd3,
		st_done       = 3'd4
	} task_state_e;

	typedef logic [`ACC_WORD_W-1:0] word_t;
	typedef logic [`ACC_ADDR_W-1:0] addr_t;
	typedef logic [`ACC_CNT_W-1:0]  cnt_t;

endpackage

//--- src/feature_reader.sv
`include "accel_consts.svh"

module feature_reader import accel_pkg::*; (
	input  logic  system_clk,
	input  logic  rst_n,
	input  logic  patch_begin,
	input  addr_t patch_src,
	input  cnt_t  patch_len,
	input  logic  slot_free,
	mem_port_if.requester rd
);

	localparam int CREDIT_W = $clog2(`ACC_FIFO_DEPTH + 1);

	addr_t               rd_addr;
	cnt_t                remain;
	logic [CREDIT_W-1:0] credit; // free result slots not yet claimed
	logic                rd_acc;

	assign rd.req   = (remain != '0) && (credit != '0);
	assign rd.addr  = rd_addr;
	assign rd.wdata = '0;
	assign rd_acc   = rd.req & rd.gnt;

	always_ff @(posedge system_clk or negedge rst_n) begin
		if (!rst_n) begin
			remain <= '0;
			credit <= CREDIT_W'(`ACC_FIFO_DEPTH);
		end else begin
			if (patch_begin)
				remain <= patch_len;
			else if (rd_acc)
				remain <= remain - `ACC_CNT_W'(1);

			case ({rd_acc, slot_free})
				2'b10:   credit <= credit - CREDIT_W'(1);
				2'b01:   credit <= credit + CREDIT_W'(1);
				default: credit <= credit;
			endcase
		end
	end

	always_ff @(posedge system_clk) begin
		if (patch_begin)
			rd_addr <= patch_src;
		else if (rd_acc)
			rd_addr <= rd_addr + addr_t'(1);
	end

endmodule

//--- src/lane_operator.sv
`include "accel_consts.svh"

module lane_operator import accel_pkg::*; (
	input  logic  system_clk,
	input  logic  rst_n,
	input  op_e   cur_op,
	input  logic  in_valid,
	input  word_t in_data,
	output logic  res_valid,
	output word_t res_data
);

	localparam int LW   = `ACC_LANE_W;
	localparam int HALF = `ACC_LANES / 2;

	word_t comb_data;

	// low lane i paired with lane i+HALF
	always_comb begin
		logic [LW-1:0] lo;
		logic [LW-1:0] hi;
		logic [LW:0]   sum;
		comb_data = '0; // upper half stays zero
		for (int i = 0; i < HALF; i++) begin
			lo  = in_data[i*LW +: LW];
			hi  = in_data[(i+HALF)*LW +: LW];
			sum = {1'b0, lo} + {1'b0, hi};
			case (cur_op)
				op_add:  comb_data[i*LW +: LW] = sum[LW] ? '1 : sum[LW-1:0]; // saturate
				op_pool: comb_data[i*LW +: LW] = (hi > lo) ? hi : lo;
				default: comb_data[i*LW +: LW] = '0;
			endcase
		end
	end

	always_ff @(posedge system_clk or negedge rst_n) begin
		if (!rst_n)
			res_valid <= 1'b0;
		else
			res_valid <= in_valid;
	end

	always_ff @(posedge system_clk) begin
		if (in_valid)
			res_data <= comb_data;
	end

endmodule

//--- src/mem_arbiter.sv
`include "accel_consts.svh"

module mem_arbiter import accel_pkg::*; (
	input  logic  system_clk,
	input  logic  rst_n,
	input  word_t mem_rdata,
	mem_port_if.arbiter rd,
	mem_port_if.arbiter wr,
	output logic  mem_en,
	output logic  mem_we,
	output addr_t mem_addr,
	output word_t mem_wdata
);

	logic rd_pending;

	// writer first, reader stalls on contention
	assign wr.gnt = wr.req;
	assign rd.gnt = rd.req & ~wr.req;

	assign mem_en    = wr.req | rd.req;
	assign mem_we    = wr.req;
	assign mem_addr  = wr.req ? wr.addr : rd.addr;
	assign mem_wdata = wr.wdata;

	// fixed one cycle read latency
	always_ff @(posedge system_clk or negedge rst_n) begin
		if (!rst_n)
			rd_pending <= 1'b0;
		else
			rd_pending <= rd.req & rd.gnt;
	end

	assign rd.rvalid = rd_pending;
	assign rd.rdata  = mem_rdata;

	// write port never returns data
	assign wr.rvalid = 1'b0;
	assign wr.rdata  = `ACC_WORD_W'(0);

endmodule

//--- src/mem_port_if.sv
`include "accel_consts.svh"

// single-beat port of one memory requester
interface mem_port_if;
	logic                   req;
	logic [`ACC_ADDR_W-1:0] addr;
	logic [`ACC_WORD_W-1:0] wdata;
	logic                   gnt;    // accepted when req && gnt
	logic [`ACC_WORD_W-1:0] rdata;
	logic                   rvalid; // one cycle after an accepted read

	modport requester (
		output req,
		output addr,
		output wdata,
		input  gnt,
		input  rdata,
		input  rvalid
	);

	modport arbiter (
		input  req,
		input  addr,
		input  wdata,
		output gnt,
		output rdata,
		output rvalid
	);
endinterface

//--- src/return_writer.sv
`include "accel_consts.svh"

module return_writer import accel_pkg::*; (
	input  logic  system_clk,
	input  logic  rst_n,
	input  logic  patch_begin,
	input  addr_t patch_dst,
	input  cnt_t  patch_len,
	input  logic  res_valid,
	input  word_t res_data,
	output logic  slot_free,
	output logic  patch_done,
	mem_port_if.requester wr
);

	localparam int DEPTH = `ACC_FIFO_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH + 1);

	word_t              fifo_mem [DEPTH];
	logic [PTR_W-1:0]   wr_ptr;
	logic [PTR_W-1:0]   rd_ptr;
	logic [CNT_W-1:0]   fill;
	addr_t              wr_addr;
	cnt_t               remain;
	logic               push;
	logic               pop;

	assign push = res_valid; // never full, reader credit covers it
	assign pop  = wr.req & wr.gnt;

	assign wr.req    = (fill != '0);
	assign wr.addr   = wr_addr;
	assign wr.wdata  = fifo_mem[rd_ptr]; // head held until granted
	assign slot_free = pop;

	always_ff @(posedge system_clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			fill       <= '0;
			remain     <= '0;
			patch_done <= 1'b0;
		end else begin
			if (push)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + PTR_W'(1);
			if (pop)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + PTR_W'(1);

			case ({push, pop})
				2'b10:   fill <= fill + CNT_W'(1);
				2'b01:   fill <= fill - CNT_W'(1);
				default: fill <= fill;
			endcase

			if (patch_begin)
				remain <= patch_len;
			else if (pop)
				remain <= remain - `ACC_CNT_W'(1);

			patch_done <= pop && (remain == `ACC_CNT_W'(1)); // last word of the patch
		end
	end

	always_ff @(posedge system_clk) begin
		if (push)
			fifo_mem[wr_ptr] <= res_data;

		if (patch_begin)
			wr_addr <= patch_dst;
		else if (pop)
			wr_addr <= wr_addr + addr_t'(1);
	end

endmodule

//--- src/task_sequencer.sv
`include "accel_consts.svh"

module task_sequencer import accel_pkg::*; (
	input  logic  system_clk,
	input  logic  rst_n,
	input  logic  task_start,
	input  logic  order_valid,
	input  op_e   order_op,
	input  addr_t order_src,
	input  addr_t order_dst,
	input  cnt_t  order_patch_num,
	input  cnt_t  order_patch_len,
	input  logic  patch_done,
	output logic  order_ready,
	output logic  op_done,
	output logic  task_active,
	output logic  patch_begin,
	output op_e   cur_op,
	output addr_t patch_src,
	output addr_t patch_dst,
	output cnt_t  patch_len
);

	task_state_e state;
	cnt_t        patch_num;
	cnt_t        patch_cnt;
	logic        order_acc;
	logic        last_patch;
	logic        next_patch;

	assign order_acc  = order_valid & order_ready;
	assign last_patch = (patch_cnt + `ACC_CNT_W'(1)) >= patch_num; // zero count runs one patch
	assign next_patch = (state == st_wait_patch) & patch_done & ~last_patch;

	assign order_ready = (state == st_wait_order);
	assign patch_begin = (state == st_load_patch);
	assign op_done     = (state == st_done);

	always_ff @(posedge system_clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= st_idle;
		end else begin
			case (state)
				st_idle: begin
					if (task_start)
						state <= st_wait_order;
				end
				st_wait_order: begin
					if (order_acc)
						state <= (order_op == op_finish) ? st_done : st_load_patch;
				end
				st_load_patch: state <= st_wait_patch;
				st_wait_patch: begin
					if (patch_done)
						state <= last_patch ? st_done : st_load_patch;
				end
				st_done: state <= (cur_op == op_finish) ? st_idle : st_wait_order;
				default: state <= st_idle;
			endcase
		end
	end

	// active from task_start until a finish order is taken
	always_ff @(posedge system_clk or negedge rst_n) begin
		if (!rst_n) begin
			task_active <= 1'b0;
			cur_op      <= op_add;
			patch_cnt   <= '0;
		end else begin
			if ((state == st_idle) && task_start)
				task_active <= 1'b1;
			else if (order_acc && (order_op == op_finish))
				task_active <= 1'b0;

			if (order_acc) begin
				cur_op    <= order_op;
				patch_cnt <= '0;
			end else if (next_patch) begin
				patch_cnt <= patch_cnt + `ACC_CNT_W'(1);
			end
		end
	end

	// order fields and per-patch base addresses
	always_ff @(posedge system_clk) begin
		if (order_acc) begin
			patch_src <= order_src;
			patch_dst <= order_dst;
			patch_len <= order_patch_len;
			patch_num <= order_patch_num;
		end else if (next_patch) begin
			patch_src <= patch_src + addr_t'(patch_len);
			patch_dst <= patch_dst + addr_t'(patch_len);
		end
	end

endmodule

//--- verification/accel_assert.sv
module accel_assert (
	input logic system_clk,
	input logic rst_n,
	input logic mem_en,
	input logic mem_we,
	input logic op_done,
	input logic order_ready,
	input logic task_active
);
	timeunit 1ns;
	timeprecision 100ps;

	we_needs_en: assert property (
		@(posedge system_clk) disable iff (!rst_n)
		mem_we |-> mem_en
	) else $error("mem_we high while mem_en is low");

	// completion is one cycle wide
	done_is_pulse: assert property (
		@(posedge system_clk) disable iff (!rst_n)
		op_done |=> !op_done
	) else $error("op_done held for more than one cycle");

	ready_needs_task: assert property (
		@(posedge system_clk) disable iff (!rst_n)
		!task_active |-> !order_ready
	) else $error("order_ready high with no active task");

endmodule

bind accel_ctrl_top accel_assert u_accel_assert (.*);

//--- verification/accel_tb.sv
`include "accel_consts.svh"

module accel_tb import accel_pkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int N_ORD = 5;
	localparam int LW    = `ACC_LANE_W;

	logic  system_clk;
	logic  rst_n;
	logic  task_start;
	logic  order_valid;
	op_e   order_op;
	addr_t order_src;
	addr_t order_dst;
	cnt_t  order_patch_num;
	cnt_t  order_patch_len;
	logic  order_ready;
	logic  op_done;
	logic  task_active;
	logic  mem_en;
	logic  mem_we;
	addr_t mem_addr;
	word_t mem_wdata;
	word_t mem_rdata = '0;

	word_t mem     [256];
	word_t exp_mem [256]; // what memory should hold

	// row 2 runs patches longer than the fifo
	op_e   ord_op  [N_ORD] = '{op_add, op_pool, op_add, op_finish, op_pool};
	addr_t ord_src [N_ORD] = '{8'h00, 8'h10, 8'h20, 8'h00, 8'h40};
	addr_t ord_dst [N_ORD] = '{8'h80, 8'h90, 8'ha0, 8'h00, 8'hc0};
	cnt_t  ord_num [N_ORD] = '{8'd1, 8'd1, 8'd3, 8'd0, 8'd2};
	cnt_t  ord_len [N_ORD] = '{8'd3, 8'd5, 8'd6, 8'd0, 8'd4};

	accel_ctrl_top uut (.*);

	initial begin
		system_clk = 1'b0;
		forever #20 system_clk = ~system_clk;
	end

	// one cycle read latency
	always @(posedge system_clk) begin
		if (mem_en && mem_we)
			mem[mem_addr] <= mem_wdata;
		else if (mem_en)
			mem_rdata <= mem[mem_addr];
	end

	task automatic fail_stop();
		$display("Regression failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_word(input word_t got, input word_t exp, input string what);
		if (got !== exp) begin
			$display("FAIL %0t ns: %s is %08h, expected %08h", $time, what, got, exp);
			fail_stop();
		end
	endtask

	task automatic check_op(input op_e got, input op_e exp, input string what);
		if (got !== exp) begin
			$display("FAIL %0t ns: %s is %s, expected %s", $time, what, got.name(), exp.name());
			fail_stop();
		end
	endtask

	task automatic check_flag(input bit got, input bit exp, input string what);
		if (got !== exp) begin
			$display("FAIL %0t ns: %s is %0b, expected %0b", $time, what, got, exp);
			fail_stop();
		end
	endtask

	// low lane i against lane i+2 with the upper half zero
	function automatic word_t lane_rule(input word_t w, input op_e op);
		word_t r;
		int    a;
		int    b;
		r = '0;
		for (int i = 0; i < 2; i++) begin
			a = w[LW*i +: LW];
			b = w[LW*(i+2) +: LW];
			if (op == op_add)
				r[LW*i +: LW] = (a + b > 255) ? 8'hff : 8'(a + b);
			else
				r[LW*i +: LW] = (a > b) ? 8'(a) : 8'(b);
		end
		return r;
	endfunction

	task automatic check_memory(input string when);
		for (int a = 0; a < 256; a++)
			check_word(mem[a], exp_mem[a], $sformatf("%s, word %02h", when, a));
	endtask

	task automatic run_order(input int i);
		addr_t s;
		addr_t d;
		while (!order_ready)
			@(negedge system_clk);
		order_op        = ord_op[i];
		order_src       = ord_src[i];
		order_dst       = ord_dst[i];
		order_patch_num = ord_num[i];
		order_patch_len = ord_len[i];
		order_valid     = 1'b1;
		@(negedge system_clk);
		order_valid = 1'b0;
		while (!op_done)
			@(negedge system_clk);
		check_op(uut.cur_op, ord_op[i], $sformatf("cur_op of row %0d", i));
		if (ord_op[i] == op_finish) begin
			check_flag(task_active, 1'b0, "task_active after finish");
			check_flag(order_ready, 1'b0, "order_ready after finish");
		end else begin
			for (int k = 0; k < ord_num[i]; k++) begin
				for (int j = 0; j < ord_len[i]; j++) begin
					s = ord_src[i] + addr_t'(k * ord_len[i] + j);
					d = ord_dst[i] + addr_t'(k * ord_len[i] + j);
					exp_mem[d] = lane_rule(exp_mem[s], ord_op[i]);
				end
			end
		end
		check_memory($sformatf("after row %0d", i));
		while (op_done) // sequencer leaves st_done
			@(negedge system_clk);
	endtask

	initial begin : watchdog
		int budget;
		budget = 400; // reset and order overhead
		for (int i = 0; i < N_ORD; i++)
			budget += int'(ord_num[i]) * int'(ord_len[i]) * 8;
		repeat (budget) @(posedge system_clk);
		$display("timeout: the DUT did not finish the orders within %0d cycles", budget);
		fail_stop();
	end

	initial begin : stimulus
		rst_n           = 1'b0;
		task_start      = 1'b0;
		order_valid     = 1'b0;
		order_op        = op_add;
		order_src       = '0;
		order_dst       = '0;
		order_patch_num = '0;
		order_patch_len = '0;
		void'($urandom(32'h8135));
		for (int a = 0; a < 256; a++) begin
			mem[a]     = $urandom();
			exp_mem[a] = mem[a];
		end
		repeat (10) @(negedge system_clk);
		rst_n = 1'b1;
		@(negedge system_clk);
		check_flag(order_ready, 1'b0, "order_ready after reset");
		check_flag(task_active, 1'b0, "task_active after reset");
		check_flag(op_done, 1'b0, "op_done after reset");
		check_flag(mem_en, 1'b0, "mem_en after reset");
		check_flag(mem_we, 1'b0, "mem_we after reset");

		// order with no open task must be dropped
		order_src       = 8'h00;
		order_dst       = 8'h80;
		order_patch_num = 8'd1;
		order_patch_len = 8'd3;
		order_valid     = 1'b1;
		@(negedge system_clk);
		order_valid = 1'b0;
		repeat (20) begin
			@(negedge system_clk);
			check_flag(mem_en, 1'b0, "mem_en without a task");
			check_flag(op_done, 1'b0, "op_done without a task");
		end
		check_memory("before task_start");

		for (int i = 0; i < N_ORD; i++) begin
			if (!task_active) begin
				task_start = 1'b1;
				@(negedge system_clk);
				task_start = 1'b0;
				check_flag(order_ready, 1'b1, "order_ready after task_start");
			end
			run_order(i);
		end
		$display("Regression passed");
		$finish;
	end

endmodule
